// File: rtl/f2c_pkg.sv
package f2c_pkg;

    // packet buffer geometry, in 512-bit flits
    localparam int PDU_AWIDTH = 9;
    localparam int PDU_DEPTH = 1 << PDU_AWIDTH;
    localparam int PDU_MAX_FLITS = 64;
    localparam int FLIT_WIDTH = 512;
    localparam int JOB_FIFO_DEPTH = 16;

    // host ring slot index
    localparam int RB_AWIDTH = 16;

    // packet buffer as seen from the data mover
    localparam logic [63:0] EP_BASE_ADDR = 64'h0000_0000_0004_0000;
    localparam logic [7:0] DONE_ID = 8'hFE;

    localparam int DESC_FIFO_DEPTH = 4;
    localparam int DESC_CNT_W = $clog2(DESC_FIFO_DEPTH + 1);

    typedef logic [FLIT_WIDTH-1:0] flit_t;

    typedef struct packed {
        logic [PDU_AWIDTH-1:0] base;
        logic [PDU_AWIDTH-1:0] size;
    } pdu_job_t;

    // write data mover descriptor, 174 bits
    typedef struct packed {
        logic [7:0]  func_nb;
        logic [7:0]  desc_id;
        logic [7:0]  app_spec;
        logic [1:0]  reserved;
        logic        single_src;
        logic        immediate;
        logic [17:0] nb_dwords;
        logic [63:0] dst_addr;
        logic [63:0] saddr_data;
    } pcie_desc_t;

endpackage

// File: rtl/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t = logic,
    parameter int DEPTH = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       push,
    input  payload_t                   push_data,
    input  logic                       pop,
    output payload_t                   pop_data,
    output logic                       empty,
    output logic                       full,
    output logic [$clog2(DEPTH+1)-1:0] count
);

    localparam int AW = $clog2(DEPTH);

    payload_t mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;

    assign pop_data = mem[rd_ptr];
    assign empty = (count == '0);
    assign full = (count == DEPTH);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: rtl/pdu_ring_buffer.sv
`timescale 1ns/1ps

module pdu_ring_buffer (
    input  logic                              clk,
    input  logic                              rst,
    input  f2c_pkg::flit_t                    wr_data,
    input  logic [f2c_pkg::PDU_AWIDTH-1:0]    wr_addr,
    input  logic                              wr_en,
    input  logic                              update_valid,
    input  logic [f2c_pkg::PDU_AWIDTH-1:0]    update_size,
    input  logic                              job_take,
    input  logic                              job_done,
    input  logic                              frb_read,
    input  logic [f2c_pkg::PDU_AWIDTH-1:0]    frb_address,
    output logic [f2c_pkg::PDU_AWIDTH-1:0]    wr_base_addr,
    output logic                              wr_base_addr_valid,
    output logic                              almost_full,
    output f2c_pkg::pdu_job_t                 job,
    output logic                              job_avail,
    output f2c_pkg::flit_t                    frb_readdata,
    output logic                              frb_readvalid
);

    localparam int AW = f2c_pkg::PDU_AWIDTH;

    f2c_pkg::flit_t mem [f2c_pkg::PDU_DEPTH];

    // one extra bit tells a full buffer from an empty one
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic [AW:0] used_flits;
    logic [AW:0] free_flits;

    logic              commit_valid;
    f2c_pkg::pdu_job_t commit_job;
    logic              job_empty;
    logic              job_full;

    logic [AW-1:0] inflight_size;
    logic          inflight_valid;

    assign wr_base_addr = wr_ptr[AW-1:0];
    assign used_flits = wr_ptr - rd_ptr;
    assign free_flits = (AW+1)'(f2c_pkg::PDU_DEPTH) - used_flits;
    assign almost_full = free_flits < (AW+1)'(f2c_pkg::PDU_MAX_FLITS);
    assign wr_base_addr_valid = !almost_full && !job_full;
    assign job_avail = !job_empty;

    // producer writes are relative to the current packet base
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_base_addr + wr_addr] <= wr_data;
        end
        frb_readdata <= mem[frb_address];
    end

    always_ff @(posedge clk) begin
        commit_job.base <= wr_base_addr;
        commit_job.size <= update_size;
        if (job_take) begin
            inflight_size <= job.size;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            commit_valid <= 1'b0;
            inflight_valid <= 1'b0;
            frb_readvalid <= 1'b0;
        end else begin
            commit_valid <= update_valid;
            frb_readvalid <= frb_read;
            if (update_valid) begin
                wr_ptr <= wr_ptr + (AW+1)'(update_size);
            end
            // free the flits of the job that just finished
            if (job_done && inflight_valid) begin
                rd_ptr <= rd_ptr + (AW+1)'(inflight_size);
                inflight_valid <= 1'b0;
            end
            if (job_take) begin
                inflight_valid <= 1'b1;
            end
        end
    end

    sync_fifo #(
        .payload_t (f2c_pkg::pdu_job_t),
        .DEPTH     (f2c_pkg::JOB_FIFO_DEPTH)
    ) job_fifo_inst (
        .clk       (clk),
        .rst       (rst),
        .push      (commit_valid),
        .push_data (commit_job),
        .pop       (job_take),
        .pop_data  (job),
        .empty     (job_empty),
        .full      (job_full),
        .count     ()
    );

endmodule

// File: rtl/desc_engine.sv
`timescale 1ns/1ps

module desc_engine (
    input  logic                              clk,
    input  logic                              rst,
    input  f2c_pkg::pdu_job_t                 job,
    input  logic                              job_avail,
    input  logic [f2c_pkg::RB_AWIDTH-1:0]     head,
    input  logic [63:0]                       kmem_addr,
    input  logic [f2c_pkg::RB_AWIDTH-1:0]     cpu_rb_size,
    input  logic [f2c_pkg::DESC_CNT_W-1:0]    desc_room,
    output logic                              job_take,
    output logic                              job_done,
    output f2c_pkg::pcie_desc_t               desc,
    output logic                              desc_push,
    output logic [f2c_pkg::RB_AWIDTH-1:0]     tail,
    output logic                              dma_done,
    output logic [31:0]                       dma_queue_full_cnt,
    output logic [31:0]                       cpu_buf_full_cnt
);

    localparam int RBW = f2c_pkg::RB_AWIDTH + 1;

    typedef enum logic [1:0] {
        IDLE,
        DESC,
        DESC_WRAP,
        DONE
    } state_t;

    state_t            state;
    f2c_pkg::pdu_job_t job_r;
    logic              room_ok;

    logic [RBW-1:0] job_size;
    logic [RBW-1:0] free_slot;
    logic [RBW-1:0] tail_sum;
    logic [RBW-1:0] size_low;
    logic [RBW-1:0] size_high;
    logic [RBW-1:0] new_tail;
    logic           wrap;

    logic [63:0] dst_addr;
    logic [63:0] src_addr;
    logic [63:0] src_addr_high;
    f2c_pkg::pcie_desc_t done_desc;

    function automatic f2c_pkg::pcie_desc_t data_desc(
        input logic [RBW-1:0] flits,
        input logic [63:0]    dst,
        input logic [63:0]    src
    );
        f2c_pkg::pcie_desc_t d;
        d = '0;
        // 16 dwords per flit
        d.nb_dwords = 18'({flits, 4'h0});
        d.dst_addr = dst;
        d.saddr_data = src;
        return d;
    endfunction

    // a push from the previous cycle is not yet counted in desc_room
    assign room_ok = int'(desc_room) >= 3 + int'(desc_push);
    assign job_take = (state == IDLE) && job_avail && room_ok;

    assign job_size = RBW'(job_r.size);

    // one host slot always stays empty
    assign free_slot = (tail >= head) ? RBW'(cpu_rb_size) - RBW'(tail) + RBW'(head) - 1'b1
                                      : RBW'(head) - RBW'(tail) - 1'b1;

    assign tail_sum = RBW'(tail) + job_size;
    assign wrap = tail_sum > RBW'(cpu_rb_size);
    assign new_tail = (tail_sum >= RBW'(cpu_rb_size)) ? tail_sum - RBW'(cpu_rb_size)
                                                      : tail_sum;
    assign size_low = RBW'(cpu_rb_size) - RBW'(tail);
    assign size_high = job_size - size_low;

    // host slot 0 holds the tail record, data starts at slot 1
    assign dst_addr = kmem_addr + ((64'(tail) + 64'd1) << 6);
    assign src_addr = f2c_pkg::EP_BASE_ADDR + (64'(job_r.base) << 6);
    assign src_addr_high = src_addr + (64'(size_low) << 6);

    always_comb begin
        done_desc = '0;
        done_desc.desc_id = f2c_pkg::DONE_ID;
        done_desc.immediate = 1'b1;
        done_desc.nb_dwords = 18'd1;
        done_desc.dst_addr = kmem_addr;
        done_desc.saddr_data = 64'(new_tail);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            desc_push <= 1'b0;
            job_done <= 1'b0;
            dma_done <= 1'b0;
            tail <= '0;
            dma_queue_full_cnt <= '0;
            cpu_buf_full_cnt <= '0;
        end else begin
            desc_push <= 1'b0;
            job_done <= 1'b0;
            dma_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (job_take) begin
                        job_r <= job;
                        state <= DESC;
                    end else if (job_avail) begin
                        // job waiting only on issue queue room
                        dma_queue_full_cnt <= dma_queue_full_cnt + 1'b1;
                    end
                end
                DESC: begin
                    if (free_slot >= job_size) begin
                        desc_push <= 1'b1;
                        if (wrap) begin
                            desc <= data_desc(size_low, dst_addr, src_addr);
                            state <= DESC_WRAP;
                        end else begin
                            desc <= data_desc(job_size, dst_addr, src_addr);
                            state <= DONE;
                        end
                    end else begin
                        cpu_buf_full_cnt <= cpu_buf_full_cnt + 1'b1;
                    end
                end
                DESC_WRAP: begin
                    // second part restarts at the first host data slot
                    desc <= data_desc(size_high, kmem_addr + 64'd64, src_addr_high);
                    desc_push <= 1'b1;
                    state <= DONE;
                end
                DONE: begin
                    desc <= done_desc;
                    desc_push <= 1'b1;
                    tail <= new_tail[f2c_pkg::RB_AWIDTH-1:0];
                    dma_done <= 1'b1;
                    job_done <= 1'b1;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: rtl/desc_issue.sv
`timescale 1ns/1ps

module desc_issue (
    input  logic                              clk,
    input  logic                              rst,
    input  f2c_pkg::pcie_desc_t               desc,
    input  logic                              desc_push,
    input  logic                              wrdm_desc_ready,
    output logic [f2c_pkg::DESC_CNT_W-1:0]    desc_room,
    output logic                              wrdm_desc_valid,
    output f2c_pkg::pcie_desc_t               wrdm_desc_data
);

    localparam int CW = f2c_pkg::DESC_CNT_W;

    f2c_pkg::pcie_desc_t fifo_data;
    logic                fifo_empty;
    logic                fifo_full;
    logic [CW-1:0]       fifo_count;
    logic                fifo_pop;

    logic ready_r1;
    logic ready_r2;
    logic ready_qualified;
    logic out_full;

    assign desc_room = CW'(f2c_pkg::DESC_FIFO_DEPTH) - fifo_count;

    // data mover takes a descriptor only after three ready cycles in a row
    assign ready_qualified = wrdm_desc_ready && ready_r1 && ready_r2;
    assign wrdm_desc_valid = out_full && ready_qualified;

    // refill the output register when it is empty or being accepted
    assign fifo_pop = !fifo_empty && (!out_full || wrdm_desc_valid);

    always_ff @(posedge clk) begin
        if (fifo_pop) begin
            wrdm_desc_data <= fifo_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_r1 <= 1'b0;
            ready_r2 <= 1'b0;
            out_full <= 1'b0;
        end else begin
            ready_r1 <= wrdm_desc_ready;
            ready_r2 <= ready_r1;
            if (fifo_pop) begin
                out_full <= 1'b1;
            end else if (wrdm_desc_valid) begin
                out_full <= 1'b0;
            end
        end
    end

    sync_fifo #(
        .payload_t (f2c_pkg::pcie_desc_t),
        .DEPTH     (f2c_pkg::DESC_FIFO_DEPTH)
    ) desc_fifo_inst (
        .clk       (clk),
        .rst       (rst),
        .push      (desc_push),
        .push_data (desc),
        .pop       (fifo_pop),
        .pop_data  (fifo_data),
        .empty     (fifo_empty),
        .full      (fifo_full),
        .count     (fifo_count)
    );

endmodule

// File: rtl/fpga2cpu_top.sv
`timescale 1ns/1ps

module fpga2cpu_top (
    input  logic                              clk,
    input  logic                              rst,
    // producer side
    input  f2c_pkg::flit_t                    wr_data,
    input  logic [f2c_pkg::PDU_AWIDTH-1:0]    wr_addr,
    input  logic                              wr_en,
    output logic [f2c_pkg::PDU_AWIDTH-1:0]    wr_base_addr,
    output logic                              wr_base_addr_valid,
    output logic                              almost_full,
    input  logic                              update_valid,
    input  logic [f2c_pkg::PDU_AWIDTH-1:0]    update_size,
    // host ring
    input  logic [f2c_pkg::RB_AWIDTH-1:0]     head,
    input  logic [63:0]                       kmem_addr,
    input  logic [f2c_pkg::RB_AWIDTH-1:0]     cpu_rb_size,
    output logic [f2c_pkg::RB_AWIDTH-1:0]     tail,
    output logic                              dma_done,
    output logic [31:0]                       dma_queue_full_cnt,
    output logic [31:0]                       cpu_buf_full_cnt,
    // write data mover
    input  logic                              wrdm_desc_ready,
    output logic                              wrdm_desc_valid,
    output f2c_pkg::pcie_desc_t               wrdm_desc_data,
    input  logic                              frb_read,
    input  logic [f2c_pkg::PDU_AWIDTH-1:0]    frb_address,
    output f2c_pkg::flit_t                    frb_readdata,
    output logic                              frb_readvalid
);

    f2c_pkg::pdu_job_t             job;
    logic                          job_avail;
    logic                          job_take;
    logic                          job_done;
    f2c_pkg::pcie_desc_t           desc;
    logic                          desc_push;
    logic [f2c_pkg::DESC_CNT_W-1:0] desc_room;

    pdu_ring_buffer pdu_ring_buffer_inst (
        .clk                (clk),
        .rst                (rst),
        .wr_data            (wr_data),
        .wr_addr            (wr_addr),
        .wr_en              (wr_en),
        .update_valid       (update_valid),
        .update_size        (update_size),
        .job_take           (job_take),
        .job_done           (job_done),
        .frb_read           (frb_read),
        .frb_address        (frb_address),
        .wr_base_addr       (wr_base_addr),
        .wr_base_addr_valid (wr_base_addr_valid),
        .almost_full        (almost_full),
        .job                (job),
        .job_avail          (job_avail),
        .frb_readdata       (frb_readdata),
        .frb_readvalid      (frb_readvalid)
    );

    desc_engine desc_engine_inst (
        .clk                (clk),
        .rst                (rst),
        .job                (job),
        .job_avail          (job_avail),
        .head               (head),
        .kmem_addr          (kmem_addr),
        .cpu_rb_size        (cpu_rb_size),
        .desc_room          (desc_room),
        .job_take           (job_take),
        .job_done           (job_done),
        .desc               (desc),
        .desc_push          (desc_push),
        .tail               (tail),
        .dma_done           (dma_done),
        .dma_queue_full_cnt (dma_queue_full_cnt),
        .cpu_buf_full_cnt   (cpu_buf_full_cnt)
    );

    desc_issue desc_issue_inst (
        .clk                (clk),
        .rst                (rst),
        .desc               (desc),
        .desc_push          (desc_push),
        .wrdm_desc_ready    (wrdm_desc_ready),
        .desc_room          (desc_room),
        .wrdm_desc_valid    (wrdm_desc_valid),
        .wrdm_desc_data     (wrdm_desc_data)
    );

endmodule

// File: tb/fpga2cpu_properties.sv
`timescale 1ns/1ps

module fpga2cpu_properties (
    input logic clk,
    input logic rst,
    input logic ready,
    input logic valid,
    input logic push,
    input logic fifo_full,
    input logic take,
    input logic avail
);

    int unsigned fail_count = 0;

    // data mover port rule
    valid_after_ready: assert property (@(posedge clk) disable iff (rst)
        valid |-> ready && $past(ready) && $past(ready, 2))
    else begin
        $error("descriptor valid without three ready cycles in a row");
        fail_count++;
    end

    no_push_when_full: assert property (@(posedge clk) disable iff (rst)
        push |-> !fifo_full)
    else begin
        $error("descriptor pushed into a full issue queue");
        fail_count++;
    end

    take_needs_job: assert property (@(posedge clk) disable iff (rst)
        take |-> avail)
    else begin
        $error("job taken while the job queue was empty");
        fail_count++;
    end

endmodule

// the issue side has no job handshake and the engine has no port or queue
bind desc_issue fpga2cpu_properties issue_props_inst (
    .clk       (clk),
    .rst       (rst),
    .ready     (wrdm_desc_ready),
    .valid     (wrdm_desc_valid),
    .push      (desc_push),
    .fifo_full (fifo_full),
    .take      (1'b0),
    .avail     (1'b1)
);

bind desc_engine fpga2cpu_properties engine_props_inst (
    .clk       (clk),
    .rst       (rst),
    .ready     (1'b0),
    .valid     (1'b0),
    .push      (1'b0),
    .fifo_full (1'b0),
    .take      (job_take),
    .avail     (job_avail)
);

// File: tb/fpga2cpu_tb.sv
`timescale 1ns/1ps

module fpga2cpu_tb;

    localparam int TIMEOUT_CYCLES = 20000;
    localparam int AW = f2c_pkg::PDU_AWIDTH;
    localparam int RBW = f2c_pkg::RB_AWIDTH;
    localparam int RB_SIZE = 64;
    localparam logic [63:0] KMEM_BASE = 64'h0000_0001_2340_0000;

    logic                clk = 1'b0;
    logic                rst;
    f2c_pkg::flit_t      wr_data;
    logic [AW-1:0]       wr_addr;
    logic                wr_en;
    logic [AW-1:0]       wr_base_addr;
    logic                wr_base_addr_valid;
    logic                almost_full;
    logic                update_valid;
    logic [AW-1:0]       update_size;
    logic [RBW-1:0]      head;
    logic [63:0]         kmem_addr;
    logic [RBW-1:0]      cpu_rb_size;
    logic [RBW-1:0]      tail;
    logic                dma_done;
    logic [31:0]         dma_queue_full_cnt;
    logic [31:0]         cpu_buf_full_cnt;
    logic                wrdm_desc_ready = 1'b0;
    logic                wrdm_desc_valid;
    f2c_pkg::pcie_desc_t wrdm_desc_data;
    logic                frb_read = 1'b0;
    logic [AW-1:0]       frb_address = '0;
    f2c_pkg::flit_t      frb_readdata;
    logic                frb_readvalid;

    // model of the packet buffer contents and of the host ring
    f2c_pkg::flit_t      shadow [f2c_pkg::PDU_DEPTH];
    f2c_pkg::pcie_desc_t exp_q [$];
    logic [AW-1:0]       read_q [$];
    logic [AW-1:0]       check_q [$];
    int                  size_q [$];
    string               test_name = "reset";
    int                  ref_tail = 0;
    int                  ref_wr_ptr = 0;
    int                  ref_used = 0;
    int                  jobs_sent = 0;
    int                  done_seen = 0;
    int                  desc_seen = 0;
    int                  cycle = 0;
    int                  ready_mode = 0;
    logic                ready_h1 = 1'b0;
    logic                ready_h2 = 1'b0;
    logic                read_pending = 1'b0;
    logic                exp_room;
    f2c_pkg::pcie_desc_t exp_desc;
    logic [AW-1:0]       chk_addr;
    logic [63:0]         flit_off;

    fpga2cpu_top fpga2cpu_top_inst (.*);

    always #5 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    // descriptors a job should produce, plus the host tail after it
    function automatic void expected_descs(
        input  int                  tail_in,
        input  int                  size,
        input  int                  base,
        input  logic [63:0]         kmem,
        input  int                  rb_size,
        output f2c_pkg::pcie_desc_t list [3],
        output int                  count,
        output int                  tail_out
    );
        int          low;
        logic [63:0] src;
        list[0] = '0;
        list[1] = '0;
        list[2] = '0;
        src = f2c_pkg::EP_BASE_ADDR + 64'(base) * 64;
        tail_out = (tail_in + size >= rb_size) ? tail_in + size - rb_size : tail_in + size;
        list[0].dst_addr = kmem + 64'(tail_in + 1) * 64;
        list[0].saddr_data = src;
        if (tail_in + size > rb_size) begin
            low = rb_size - tail_in;
            list[0].nb_dwords = 18'(low * 16);
            list[1].nb_dwords = 18'((size - low) * 16);
            list[1].dst_addr = kmem + 64'd64;
            list[1].saddr_data = src + 64'(low) * 64;
            count = 3;
        end else begin
            list[0].nb_dwords = 18'(size * 16);
            count = 2;
        end
        list[count-1].immediate = 1'b1;
        list[count-1].desc_id = f2c_pkg::DONE_ID;
        list[count-1].nb_dwords = 18'd1;
        list[count-1].dst_addr = kmem;
        list[count-1].saddr_data = 64'(tail_out);
    endfunction

    task automatic send_packet(input int size);
        f2c_pkg::pcie_desc_t list [3];
        int                  count;
        int                  new_tail;
        f2c_pkg::flit_t      flit;
        while (!wr_base_addr_valid) begin
            @(posedge clk);
            #1;
        end
        assert (int'(wr_base_addr) == ref_wr_ptr) else
            abort_run($sformatf("Fail %s: expected base %0d, actual %0d",
                test_name, ref_wr_ptr, wr_base_addr));
        for (int i = 0; i < size; i++) begin
            for (int k = 0; k < 16; k++) begin
                flit[32*k +: 32] = $urandom;
            end
            wr_en = 1'b1;
            wr_addr = AW'(i);
            wr_data = flit;
            shadow[(ref_wr_ptr + i) % f2c_pkg::PDU_DEPTH] = flit;
            @(posedge clk);
            #1;
        end
        wr_en = 1'b0;
        update_valid = 1'b1;
        update_size = AW'(size);
        expected_descs(ref_tail, size, ref_wr_ptr, KMEM_BASE, RB_SIZE, list, count, new_tail);
        for (int j = 0; j < count; j++) begin
            exp_q.push_back(list[j]);
        end
        ref_tail = new_tail;
        ref_wr_ptr = (ref_wr_ptr + size) % f2c_pkg::PDU_DEPTH;
        jobs_sent++;
        @(posedge clk);
        #1;
        // the write pointer has moved past the committed flits
        ref_used += size;
        size_q.push_back(size);
        update_valid = 1'b0;
    endtask

    // every expected descriptor seen and every flit read back
    task automatic wait_idle();
        while (exp_q.size() != 0 || read_q.size() != 0 || check_q.size() != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic check_tail();
        assert (int'(tail) == ref_tail) else
            abort_run($sformatf("Fail %s: expected tail %0d, actual %0d",
                test_name, ref_tail, tail));
    endtask

    always @(posedge clk) begin
        cycle++;
        if (cycle >= TIMEOUT_CYCLES) begin
            abort_run("timeout: the tests did not finish within the cycle limit");
        end
    end

    // data mover model, ready pattern and flit reads
    always begin
        @(posedge clk);
        #1;
        case (ready_mode)
            0: wrdm_desc_ready = 1'b1;
            1: wrdm_desc_ready = 1'b0;
            default: wrdm_desc_ready = ($urandom % 4) != 0;
        endcase
        if (read_q.size() != 0) begin
            frb_read = 1'b1;
            frb_address = read_q.pop_front();
            check_q.push_back(frb_address);
        end else begin
            frb_read = 1'b0;
        end
    end

    // compare at the falling edge where all outputs are settled
    always @(negedge clk) begin
        if (!rst) begin
            if (wrdm_desc_valid) begin
                assert (wrdm_desc_ready && ready_h1 && ready_h2) else
                    abort_run("descriptor valid came without three ready cycles in a row");
                assert (exp_q.size() != 0) else
                    abort_run("the data mover got a descriptor that no job accounts for");
                exp_desc = exp_q.pop_front();
                assert (wrdm_desc_data == exp_desc) else
                    abort_run($sformatf("Fail %s: expected %h, actual %h",
                        test_name, exp_desc, wrdm_desc_data));
                desc_seen++;
                if (!wrdm_desc_data.immediate) begin
                    flit_off = (wrdm_desc_data.saddr_data - f2c_pkg::EP_BASE_ADDR) >> 6;
                    for (int i = 0; i < int'(wrdm_desc_data.nb_dwords) / 16; i++) begin
                        read_q.push_back(AW'(flit_off + 64'(i)));
                    end
                end
            end
            assert (frb_readvalid == read_pending) else
                abort_run("read data valid did not come exactly one cycle after the read");
            if (frb_readvalid) begin
                chk_addr = check_q.pop_front();
                assert (frb_readdata == shadow[chk_addr]) else
                    abort_run($sformatf("Fail %s: flit %0d expected %h, actual %h",
                        test_name, chk_addr, shadow[chk_addr], frb_readdata));
            end
            // only a few jobs wait at once, so the job queue never fills
            exp_room = (f2c_pkg::PDU_DEPTH - ref_used) >= f2c_pkg::PDU_MAX_FLITS;
            assert (almost_full == !exp_room) else
                abort_run($sformatf("Fail %s: expected almost_full %0b, actual %0b",
                    test_name, !exp_room, almost_full));
            assert (wr_base_addr_valid == exp_room) else
                abort_run($sformatf("Fail %s: expected wr_base_addr_valid %0b, actual %0b",
                    test_name, exp_room, wr_base_addr_valid));
            if (dma_done) begin
                done_seen++;
                // the oldest job gives its flits back
                ref_used -= size_q.pop_front();
            end
            read_pending = frb_read;
            ready_h2 = ready_h1;
            ready_h1 = wrdm_desc_ready;
        end
    end

    initial begin
        int          old_tail;
        int          seen_before;
        logic [31:0] stall_before;
        logic [31:0] qfull_before;
        int unsigned prop_fails;
        void'($urandom(32'hbe1e6ff5));
        rst = 1'b1;
        wr_data = '0;
        wr_addr = '0;
        wr_en = 1'b0;
        update_valid = 1'b0;
        update_size = '0;
        head = '0;
        kmem_addr = KMEM_BASE;
        cpu_rb_size = RBW'(RB_SIZE);
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        test_name = "no_wrap";
        send_packet(5);
        wait_idle();
        check_tail();
        head = RBW'(ref_tail);

        // 5 + 50 lands at 55, then 20 more runs past the ring end
        test_name = "wrap_split";
        send_packet(50);
        wait_idle();
        check_tail();
        head = RBW'(ref_tail);
        send_packet(20);
        wait_idle();
        check_tail();
        head = RBW'(ref_tail);

        test_name = "exact_end";
        send_packet(RB_SIZE - ref_tail);
        wait_idle();
        check_tail();
        head = RBW'(ref_tail);

        // two free host slots against an 8 flit job
        test_name = "host_full";
        old_tail = ref_tail;
        head = RBW'((ref_tail + 3) % RB_SIZE);
        stall_before = cpu_buf_full_cnt;
        seen_before = desc_seen;
        send_packet(8);
        repeat (40) @(posedge clk);
        #1;
        assert (desc_seen == seen_before) else
            abort_run("a descriptor was issued while the host ring had no room");
        assert (cpu_buf_full_cnt > stall_before) else
            abort_run($sformatf("Fail %s: expected cpu_buf_full_cnt above %0d, actual %0d",
                test_name, stall_before, cpu_buf_full_cnt));
        head = RBW'(old_tail);
        wait_idle();
        check_tail();
        head = RBW'(ref_tail);

        test_name = "ready_gaps";
        ready_mode = 1;
        qfull_before = dma_queue_full_cnt;
        for (int j = 0; j < 6; j++) begin
            send_packet(int'($urandom % 8) + 1);
        end
        ready_mode = 2;
        wait_idle();
        check_tail();
        assert (dma_queue_full_cnt > qfull_before) else
            abort_run($sformatf("Fail %s: expected dma_queue_full_cnt above %0d, actual %0d",
                test_name, qfull_before, dma_queue_full_cnt));

        prop_fails = fpga2cpu_top_inst.desc_issue_inst.issue_props_inst.fail_count
                   + fpga2cpu_top_inst.desc_engine_inst.engine_props_inst.fail_count;
        if (done_seen == jobs_sent && prop_fails == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("Fail end: expected %0d done pulses, actual %0d, property failures %0d",
                jobs_sent, done_seen, prop_fails);
            $display("TEST FAIL");
            $fatal(1, "run ended with errors");
        end
    end

endmodule

// File: build.f
rtl/f2c_pkg.sv
rtl/sync_fifo.sv
rtl/pdu_ring_buffer.sv
rtl/desc_engine.sv
rtl/desc_issue.sv
rtl/fpga2cpu_top.sv
tb/fpga2cpu_properties.sv
tb/fpga2cpu_tb.sv

// File: Makefile
SRCS := $(shell cat build.f)

.PHONY: run clean

run: obj_dir/Vfpga2cpu_tb
	@out=$$(./obj_dir/Vfpga2cpu_tb 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q '^TEST PASS$$'

obj_dir/Vfpga2cpu_tb: build.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal \
		-f build.f --top-module fpga2cpu_tb

clean:
	rm -rf obj_dir
